// File: gps_pkg.sv
`default_nettype none

// Shared constants for the C/A tracking channel
package gps_pkg;

   localparam int CHIPS_PER_EPOCH   = 1023;             // Gold code length
   localparam int SAMPLES_PER_CHIP  = 16;               // Hold count per chip
   localparam int SAMPLES_PER_EPOCH = CHIPS_PER_EPOCH * SAMPLES_PER_CHIP;  // 16368

   localparam int ACC_W   = 18;                         // Signed, holds +/-65472
   localparam int PHASE_W = 14;                         // {chip, sample in chip}
   localparam int PRN_W   = 5;                          // Value 0 means PRN 32

   // G2 phase selector per PRN
   // Upper nibble first stage, lower nibble second stage, stages count from 1
   localparam logic [7:0] G2_TAPS [32] = '{
      8'h49, 8'h26,                                     // PRN 32, 1
      8'h37, 8'h48,                                     // PRN 2, 3
      8'h59, 8'h19,                                     // PRN 4, 5
      8'h2A, 8'h18,                                     // PRN 6, 7
      8'h29, 8'h3A,                                     // PRN 8, 9
      8'h23, 8'h34,                                     // PRN 10, 11
      8'h56, 8'h67,                                     // PRN 12, 13
      8'h78, 8'h89,                                     // PRN 14, 15
      8'h9A, 8'h14,                                     // PRN 16, 17
      8'h25, 8'h36,                                     // PRN 18, 19
      8'h47, 8'h58,                                     // PRN 20, 21
      8'h69, 8'h13,                                     // PRN 22, 23
      8'h46, 8'h57,                                     // PRN 24, 25
      8'h68, 8'h79,                                     // PRN 26, 27
      8'h8A, 8'h16,                                     // PRN 28, 29
      8'h27, 8'h38                                      // PRN 30, 31
   };

   // Wishbone word addresses
   localparam logic [1:0] REG_CTRL   = 2'd0;            // R/W enable and PRN
   localparam logic [1:0] REG_STATUS = 2'd1;            // RO phase and epoch count
   localparam logic [1:0] REG_DUMP   = 2'd2;            // RO last correlation sum

   // CTRL fields
   localparam int CTRL_EN_BIT  = 0;                     // Channel enable
   localparam int CTRL_PRN_LSB = 4;                     // PRN in bits 8:4

endpackage

`default_nettype wire

// File: hex_driver.sv
`timescale 1ns/1ps
`default_nettype none

module hex_driver (
   input  logic [3:0] nibble,
   output logic [6:0] seg       // {g,f,e,d,c,b,a}, low lights
);

   always_comb begin
      case (nibble)
         4'h0: seg = 7'h40;
         4'h1: seg = 7'h79;
         4'h2: seg = 7'h24;
         4'h3: seg = 7'h30;
         4'h4: seg = 7'h19;
         4'h5: seg = 7'h12;
         4'h6: seg = 7'h02;
         4'h7: seg = 7'h78;
         4'h8: seg = 7'h00;     // All segments on
         4'h9: seg = 7'h10;
         4'hA: seg = 7'h08;
         4'hB: seg = 7'h03;     // Lower case b
         4'hC: seg = 7'h46;
         4'hD: seg = 7'h21;     // Lower case d
         4'hE: seg = 7'h06;
         default: seg = 7'h0E;  // F
      endcase
   end

endmodule

`default_nettype wire

// File: ca_code_gen.sv
`timescale 1ns/1ps
`default_nettype none

module ca_code_gen (
   input  logic                      clk_sample,
   input  logic                      rst_n,
   input  logic                      run,        // Low holds reset chip
   input  logic                      chip_adv,   // Step on this edge
   input  logic [gps_pkg::PRN_W-1:0] prn,
   output logic                      ca_bit,
   output logic [9:0]                chip_idx,   // 0 to 1022
   output logic                      last_chip   // Chip 1022 presented
);

   logic [9:0] g1;                                  // Stage n held in bit n-1
   logic [9:0] g2;
   logic [7:0] tap_pair;                            // Selector entry for prn
   logic [3:0] tap_a;
   logic [3:0] tap_b;
   logic       g1_fb;
   logic       g2_fb;

   assign tap_pair = gps_pkg::G2_TAPS[prn];
   assign tap_a    = tap_pair[7:4];                 // First G2 stage
   assign tap_b    = tap_pair[3:0];                 // Second G2 stage

   assign g1_fb = g1[2] ^ g1[9];                    // Taps 3, 10
   assign g2_fb = g2[1] ^ g2[2] ^ g2[5] ^ g2[7] ^ g2[8] ^ g2[9];  // Taps 2,3,6,8,9,10

   // Chip out of G1 stage 10 and the two selected G2 stages
   assign ca_bit = g1[9] ^ g2[tap_a - 4'd1] ^ g2[tap_b - 4'd1];

   assign last_chip = (chip_idx == 10'(gps_pkg::CHIPS_PER_EPOCH - 1));

   always_ff @(posedge clk_sample or negedge rst_n) begin
      if (!rst_n) begin
         g1       <= '1;                            // All ones seed
         g2       <= '1;
         chip_idx <= '0;
      end else if (!run) begin
         g1       <= '1;                            // Park at chip 0
         g2       <= '1;
         chip_idx <= '0;
      end else if (chip_adv) begin
         if (last_chip) begin
            g1       <= '1;                         // Epoch wrap, reload
            g2       <= '1;
            chip_idx <= '0;
         end else begin
            g1       <= {g1[8:0], g1_fb};           // Shift toward stage 10
            g2       <= {g2[8:0], g2_fb};
            chip_idx <= chip_idx + 10'd1;
         end
      end
   end

   // Chip index wraps before reaching the code length
   a_chip_range: assert property (
      @(posedge clk_sample) disable iff (!rst_n)
      chip_idx < 10'(gps_pkg::CHIPS_PER_EPOCH)
   ) else $error("chip_idx out of range");

endmodule

`default_nettype wire

// File: ca_upsampler.sv
`timescale 1ns/1ps
`default_nettype none

module ca_upsampler (
   input  logic                        clk_sample,
   input  logic                        rst_n,
   input  logic                        run,
   input  logic [gps_pkg::PRN_W-1:0]   prn,
   output logic                        ca_bit,      // Held for 16 samples
   output logic                        epoch_end,   // Last sample of chip 1022
   output logic [gps_pkg::PHASE_W-1:0] code_phase   // Samples into epoch
);

   logic [3:0] samp_cnt;                            // Sample within chip
   logic [9:0] chip_idx;
   logic       chip_adv;
   logic       last_chip;

   ca_code_gen code_gen0 (
      .clk_sample (clk_sample),
      .rst_n      (rst_n),
      .run        (run),
      .chip_adv   (chip_adv),
      .prn        (prn),
      .ca_bit     (ca_bit),
      .chip_idx   (chip_idx),
      .last_chip  (last_chip)
   );

   // Step the code on the last held sample
   assign chip_adv  = run && (samp_cnt == 4'(gps_pkg::SAMPLES_PER_CHIP - 1));
   assign epoch_end = chip_adv && last_chip;        // Sample 16367 of epoch

   assign code_phase = {chip_idx, samp_cnt};        // chip * 16 + sample

   always_ff @(posedge clk_sample or negedge rst_n) begin
      if (!rst_n) begin
         samp_cnt <= '0;
      end else if (!run) begin
         samp_cnt <= '0;                            // First run cycle is sample 0
      end else begin
         samp_cnt <= samp_cnt + 4'd1;               // Wraps right after chip_adv
      end
   end

   // Epoch end is followed by chip 0, sample 0
   a_epoch_wrap: assert property (
      @(posedge clk_sample) disable iff (!rst_n)
      epoch_end |=> (code_phase == '0)
   ) else $error("code phase did not wrap after epoch_end");

endmodule

`default_nettype wire

// File: track_correlator.sv
`timescale 1ns/1ps
`default_nettype none

module track_correlator (
   input  logic                             clk_sample,
   input  logic                             rst_n,
   input  logic                             run,
   input  logic [2:0]                       bb_sample,   // {sign, magnitude}
   input  logic                             ca_bit,
   input  logic                             epoch_end,
   output logic                             dump_valid,  // One cycle per epoch
   output logic signed [gps_pkg::ACC_W-1:0] dump_value
);

   logic                             s1_run;        // Stage 1 flags
   logic                             s1_epoch;
   logic [2:0]                       s1_sample;     // Stage 1 payload
   logic                             s1_code;
   logic [3:0]                       mag1;          // 1 to 4
   logic                             neg;
   logic signed [3:0]                weight;
   logic signed [gps_pkg::ACC_W-1:0] acc;
   logic signed [gps_pkg::ACC_W:0]   sum_wide;      // One guard bit

   assign mag1   = {2'b00, s1_sample[1:0]} + 4'd1;
   assign neg    = s1_sample[2] ^ ~s1_code;         // Code 1 keeps sample sign
   assign weight = neg ? -mag1 : mag1;

   assign sum_wide = {acc[gps_pkg::ACC_W-1], acc}
                   + {{(gps_pkg::ACC_W - 3){weight[3]}}, weight};

   always_ff @(posedge clk_sample or negedge rst_n) begin
      if (!rst_n) begin
         s1_run   <= 1'b0;
         s1_epoch <= 1'b0;
      end else begin
         s1_run   <= run;
         s1_epoch <= epoch_end;
      end
   end

   always_ff @(posedge clk_sample) begin
      s1_sample <= bb_sample;
      s1_code   <= ca_bit;
   end

   always_ff @(posedge clk_sample or negedge rst_n) begin
      if (!rst_n) begin
         acc        <= '0;
         dump_valid <= 1'b0;
         dump_value <= '0;                          // Display reads zero
      end else begin
         dump_valid <= 1'b0;
         if (!run) begin
            acc <= '0;                              // Drop partial epoch
         end else if (s1_run) begin
            if (s1_epoch) begin
               dump_value <= sum_wide[gps_pkg::ACC_W-1:0];  // Includes last product
               dump_valid <= 1'b1;
               acc        <= '0;                    // Next product starts fresh
            end else begin
               acc <= sum_wide[gps_pkg::ACC_W-1:0];
            end
         end
      end
   end

   // Running sum stays within one full epoch of maximum weight
   a_no_overflow: assert property (
      @(posedge clk_sample) disable iff (!rst_n)
      s1_run |-> (sum_wide <= gps_pkg::SAMPLES_PER_EPOCH * 4 &&
                  sum_wide >= -(gps_pkg::SAMPLES_PER_EPOCH * 4))
   ) else $error("accumulator overflow");

   a_dump_needs_run: assert property (
      @(posedge clk_sample) disable iff (!rst_n)
      !run |=> !dump_valid
   ) else $error("dump while channel stopped");

endmodule

`default_nettype wire

// File: wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wb_regs (
   input  logic                             clk_sample,
   input  logic                             rst_n,
   input  logic                             wb_cyc,
   input  logic                             wb_stb,
   input  logic                             wb_we,
   input  logic [1:0]                       wb_adr,
   input  logic [3:0]                       wb_sel,
   input  logic [31:0]                      wb_dat_w,
   output logic [31:0]                      wb_dat_r,
   output logic                             wb_ack,
   output logic                             run,
   output logic [gps_pkg::PRN_W-1:0]        prn,
   input  logic [gps_pkg::PHASE_W-1:0]      code_phase,
   input  logic                             dump_valid,
   input  logic signed [gps_pkg::ACC_W-1:0] dump_value
);

   logic                             ctrl_en;
   logic [gps_pkg::PRN_W-1:0]        ctrl_prn;
   logic [15:0]                      epoch_cnt;
   logic signed [gps_pkg::ACC_W-1:0] dump_reg;
   logic                             acc_go;        // Access accepted this edge
   logic [31:0]                      ctrl_word;
   logic [31:0]                      ctrl_merged;   // CTRL after byte lanes
   logic [31:0]                      rd_word;

   assign acc_go = wb_cyc && wb_stb && !wb_ack;     // Ack never back to back
   assign run    = ctrl_en;
   assign prn    = ctrl_prn;

   always_comb begin
      ctrl_word = '0;
      ctrl_word[gps_pkg::CTRL_EN_BIT] = ctrl_en;
      ctrl_word[gps_pkg::CTRL_PRN_LSB +: gps_pkg::PRN_W] = ctrl_prn;
   end

   always_comb begin
      for (int b = 0; b < 4; b++) begin
         ctrl_merged[8*b +: 8] = wb_sel[b] ? wb_dat_w[8*b +: 8] : ctrl_word[8*b +: 8];
      end
   end

   always_comb begin
      rd_word = '0;                                 // Unmapped reads zero
      case (wb_adr)
         gps_pkg::REG_CTRL: rd_word = ctrl_word;
         gps_pkg::REG_STATUS: begin
            rd_word[gps_pkg::PHASE_W-1:0] = code_phase;
            rd_word[31:16]                = epoch_cnt;
         end
         gps_pkg::REG_DUMP:
            rd_word = {{(32 - gps_pkg::ACC_W){dump_reg[gps_pkg::ACC_W-1]}}, dump_reg};
         default: rd_word = '0;
      endcase
   end

   always_ff @(posedge clk_sample or negedge rst_n) begin
      if (!rst_n) begin
         wb_ack   <= 1'b0;
         ctrl_en  <= 1'b0;
         ctrl_prn <= '0;
      end else begin
         wb_ack <= acc_go;
         if (acc_go && wb_we && wb_adr == gps_pkg::REG_CTRL) begin
            ctrl_en  <= ctrl_merged[gps_pkg::CTRL_EN_BIT];
            ctrl_prn <= ctrl_merged[gps_pkg::CTRL_PRN_LSB +: gps_pkg::PRN_W];
         end
      end
   end

   always_ff @(posedge clk_sample or negedge rst_n) begin
      if (!rst_n) begin
         epoch_cnt <= '0;
         dump_reg  <= '0;
      end else begin
         if (dump_valid) dump_reg <= dump_value;    // Old value seen by same-edge read
         if (!ctrl_en) begin
            epoch_cnt <= '0;                        // Stop clears the count
         end else if (dump_valid) begin
            epoch_cnt <= epoch_cnt + 16'd1;
         end
      end
   end

   always_ff @(posedge clk_sample) begin
      if (acc_go) wb_dat_r <= rd_word;              // Valid with ack
   end

   a_ack_single: assert property (
      @(posedge clk_sample) disable iff (!rst_n)
      wb_ack |=> !wb_ack
   ) else $error("wb_ack high two cycles");

endmodule

`default_nettype wire

// File: gps_track_top.sv
`timescale 1ns/1ps
`default_nettype none

module gps_track_top (
   input  logic        clk_sample,
   input  logic        rst_n,
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  logic [1:0]  wb_adr,
   input  logic [3:0]  wb_sel,
   input  logic [31:0] wb_dat_w,
   output logic [31:0] wb_dat_r,
   output logic        wb_ack,
   input  logic [2:0]  bb_sample,   // {sign, magnitude}
   output logic        ca_bit,
   output logic        epoch_end,
   output logic [6:0]  hex0,
   output logic [6:0]  hex1,
   output logic [6:0]  hex2,
   output logic [6:0]  hex3
);

   logic                             run;
   logic [gps_pkg::PRN_W-1:0]        prn;
   logic [gps_pkg::PHASE_W-1:0]      code_phase;
   logic                             dump_valid;
   logic signed [gps_pkg::ACC_W-1:0] dump_value;

   wb_regs regs0 (
      .clk_sample (clk_sample),
      .rst_n      (rst_n),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_sel     (wb_sel),
      .wb_dat_w   (wb_dat_w),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .run        (run),
      .prn        (prn),
      .code_phase (code_phase),
      .dump_valid (dump_valid),
      .dump_value (dump_value)
   );

   ca_upsampler upsampler0 (
      .clk_sample (clk_sample),
      .rst_n      (rst_n),
      .run        (run),
      .prn        (prn),
      .ca_bit     (ca_bit),
      .epoch_end  (epoch_end),
      .code_phase (code_phase)
   );

   track_correlator corr0 (
      .clk_sample (clk_sample),
      .rst_n      (rst_n),
      .run        (run),
      .bb_sample  (bb_sample),
      .ca_bit     (ca_bit),
      .epoch_end  (epoch_end),
      .dump_valid (dump_valid),
      .dump_value (dump_value)
   );

   // Dump bits 17:2, two LSBs dropped
   hex_driver hex_drv0 (.nibble(dump_value[5:2]),   .seg(hex0));
   hex_driver hex_drv1 (.nibble(dump_value[9:6]),   .seg(hex1));
   hex_driver hex_drv2 (.nibble(dump_value[13:10]), .seg(hex2));
   hex_driver hex_drv3 (.nibble(dump_value[17:14]), .seg(hex3));

endmodule

`default_nettype wire

// File: tb_gps_model.svh
`ifndef TB_GPS_MODEL_SVH
`define TB_GPS_MODEL_SVH

localparam int MODE_MATCHED  = 0;                 // Sample sign follows the code
localparam int MODE_INVERTED = 1;                 // Sample sign against the code
localparam int MODE_CONST    = 2;                 // Always positive

// Active-low {g,f,e,d,c,b,a} for digits 0 to F
localparam logic [6:0] SEG_REF [16] = '{
   7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
   7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
};

// One epoch of chips, bit index is the chip number
function automatic logic [1022:0] ca_sequence(input int prn);
   bit [1:10]     g1;                             // Stage numbers as in the ICD
   bit [1:10]     g2;
   int            sa;
   int            sb;
   int            c;
   logic [1022:0] seq;
   g1 = '1;
   g2 = '1;
   sa = int'(gps_pkg::G2_TAPS[prn % 32][7:4]);
   sb = int'(gps_pkg::G2_TAPS[prn % 32][3:0]);
   for (c = 0; c < gps_pkg::CHIPS_PER_EPOCH; c++) begin
      seq[c] = g1[10] ^ g2[sa] ^ g2[sb];
      g1 = {g1[3] ^ g1[10], g1[1:9]};
      g2 = {g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10], g2[1:9]};
   end
   return seq;
endfunction

// Baseband word for one sample, sign 0 is positive
function automatic logic [2:0] sample_for(input int mode, input int mag, input logic code);
   logic sign;
   case (mode)
      MODE_MATCHED:  sign = ~code;                // Product comes out positive
      MODE_INVERTED: sign = code;
      default:       sign = 1'b0;
   endcase
   return {sign, 2'(mag)};
endfunction

// Sum over one epoch
function automatic int expected_dump(input int mode, input int mag, input int ones);
   int weight;
   int zeros;
   weight = mag + 1;                              // Magnitude code 0 weighs 1
   zeros  = gps_pkg::CHIPS_PER_EPOCH - ones;
   if (mode == MODE_MATCHED) return gps_pkg::SAMPLES_PER_EPOCH * weight;
   if (mode == MODE_INVERTED) return -(gps_pkg::SAMPLES_PER_EPOCH * weight);
   return gps_pkg::SAMPLES_PER_CHIP * (ones - zeros) * weight;  // Code 0 chips subtract
endfunction

`endif

// File: tb_gps_track.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gps_track;

   `include "tb_gps_model.svh"

   localparam int NUM_ROWS    = 8;                // Last two rows are random
   localparam int ACK_TIMEOUT = 8;
   localparam int POLL_LIMIT  = gps_pkg::SAMPLES_PER_EPOCH;

   logic        clk_sample;
   logic        rst_n;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [1:0]  wb_adr;
   logic [3:0]  wb_sel;
   logic [31:0] wb_dat_w;
   logic [31:0] wb_dat_r;
   logic        wb_ack;
   logic [2:0]  bb_sample;
   logic        ca_bit;
   logic        epoch_end;
   logic [6:0]  hex0;
   logic [6:0]  hex1;
   logic [6:0]  hex2;
   logic [6:0]  hex3;

   int          errors;
   int          tests_run;
   int          tests_failed;
   logic [31:0] lfsr_state;
   int          row_prn [NUM_ROWS];
   int          row_mode [NUM_ROWS];
   int          row_mag [NUM_ROWS];
   int          row_exp [NUM_ROWS];

   gps_track_top dut0 (
      .clk_sample (clk_sample), .rst_n (rst_n),
      .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
      .wb_sel (wb_sel), .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
      .bb_sample (bb_sample), .ca_bit (ca_bit), .epoch_end (epoch_end),
      .hex0 (hex0), .hex1 (hex1), .hex2 (hex2), .hex3 (hex3)
   );

   initial begin
      clk_sample = 1'b0;
      forever #20 clk_sample = ~clk_sample;       // 25 MHz
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32,22,2,1
   endfunction

   task automatic take_bits(input int nbits, output int val);
      int i;
      val = 0;
      for (i = 0; i < nbits; i++) begin
         lfsr_state = lfsr_next(lfsr_state);      // One step per bit
         val = (val << 1) | int'(lfsr_state[0]);
      end
   endtask

   function automatic logic [31:0] ctrl_value(input int prn, input logic en);
      return (32'(prn % 32) << gps_pkg::CTRL_PRN_LSB) | 32'(en);
   endfunction

   task automatic report_mismatch(input string what, input int got, input int exp);
      errors++;
      $display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
   endtask

   task automatic abort_run(input string why);
      $display("Run stopped at %0t: %s", $time, why);
      $display("TEST RESULT: FAIL");
      $finish;
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before) begin
         $display("test %-8s ok", name);
      end else begin
         tests_failed++;
         $display("test %-8s failed", name);
      end
   endtask

   // One classic cycle, called on a falling edge, returns one cycle after the ack
   task automatic wb_access(input logic we, input logic [1:0] adr, input logic [3:0] sel,
                            input logic [31:0] wdata, output logic [31:0] rdata);
      int waited;
      waited   = 0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_sel   = sel;
      wb_dat_w = wdata;
      @(negedge clk_sample);
      while (!wb_ack) begin
         if (waited == ACK_TIMEOUT) abort_run("slave never raised wb_ack");
         waited++;
         @(negedge clk_sample);
      end
      rdata  = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      @(negedge clk_sample);
      if (wb_ack) report_mismatch("wb_ack held a second cycle", 1, 0);
   endtask

   task automatic wb_write(input logic [1:0] adr, input logic [31:0] data,
                           input logic [3:0] sel);
      logic [31:0] ignored;
      wb_access(1'b1, adr, sel, data, ignored);
   endtask

   task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
      wb_access(1'b0, adr, 4'hf, 32'h0, data);
   endtask

   // Poll STATUS until the epoch count reaches target
   task automatic wait_epoch_count(input int target);
      logic [31:0] st;
      int          polls;
      polls = 0;
      wb_read(gps_pkg::REG_STATUS, st);
      while (int'(st[31:16]) != target) begin
         if (int'(st[31:16]) != target - 1) begin
            report_mismatch("epoch count step", int'(st[31:16]), target - 1);
         end
         if (polls == POLL_LIMIT) abort_run("epoch count never reached its next value");
         polls++;
         wb_read(gps_pkg::REG_STATUS, st);
      end
      if (int'(st[13:0]) >= gps_pkg::SAMPLES_PER_EPOCH) begin
         report_mismatch("code phase range", int'(st[13:0]), 0);
      end
   endtask

   task automatic run_row(input int r);
      logic [1022:0] code;
      logic [9:0]    first10;
      logic [31:0]   rd;
      logic [17:0]   e18;
      logic [27:0]   segs_exp;
      int            n;
      int            chip;
      int            ones_seen;
      int            epoch_hits;
      code       = ca_sequence(row_prn[r]);
      first10    = '0;
      ones_seen  = 0;
      epoch_hits = 0;
      wb_write(gps_pkg::REG_CTRL, ctrl_value(row_prn[r], 1'b0), 4'hf);  // Stop, count cleared
      bb_sample = sample_for(row_mode[r], row_mag[r], code[0]);
      wb_write(gps_pkg::REG_CTRL, ctrl_value(row_prn[r], 1'b1), 4'hf);
      for (n = 1; n < gps_pkg::SAMPLES_PER_EPOCH; n++) begin  // Sample 0 already passed
         chip = n / gps_pkg::SAMPLES_PER_CHIP;
         bb_sample = sample_for(row_mode[r], row_mag[r], code[chip]);
         if (n % gps_pkg::SAMPLES_PER_CHIP == gps_pkg::SAMPLES_PER_CHIP / 2) begin  // Mid chip
            if (ca_bit !== code[chip]) begin
               report_mismatch($sformatf("ca_bit chip %0d", chip), int'(ca_bit),
                               int'(code[chip]));
            end
            ones_seen += int'(ca_bit);
            if (chip < 10) first10[9 - chip] = ca_bit;
         end
         if (epoch_end) begin
            epoch_hits++;
            if (n != gps_pkg::SAMPLES_PER_EPOCH - 1) begin
               report_mismatch("epoch_end position", n, gps_pkg::SAMPLES_PER_EPOCH - 1);
            end
         end
         @(negedge clk_sample);
      end
      if (epoch_hits != 1) report_mismatch("epoch_end pulses per epoch", epoch_hits, 1);
      if (ones_seen != 512) report_mismatch("ones per epoch", ones_seen, 512);
      if (row_prn[r] == 1 && first10 != 10'o1440) begin
         report_mismatch("PRN 1 first chips", int'(first10), 'o1440);
      end
      wait_epoch_count(1);
      wb_read(gps_pkg::REG_DUMP, rd);
      if ($signed(rd) != row_exp[r]) report_mismatch("DUMP", $signed(rd), row_exp[r]);
      e18      = 18'(row_exp[r]);
      segs_exp = {SEG_REF[e18[17:14]], SEG_REF[e18[13:10]],
                  SEG_REF[e18[9:6]], SEG_REF[e18[5:2]]};
      if ({hex3, hex2, hex1, hex0} !== segs_exp) begin
         report_mismatch("hex digits", int'({hex3, hex2, hex1, hex0}), int'(segs_exp));
      end
      wait_epoch_count(2);                        // One more per epoch
   endtask

   initial begin
      logic [31:0]   rd;
      logic [1022:0] last_code;
      int            errs0;
      int            r;
      int            v;
      logic          park_bit;
      rst_n      = 1'b0;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = 2'd0;
      wb_sel     = 4'h0;
      wb_dat_w   = 32'h0;
      bb_sample  = 3'b000;
      errors     = 0;
      tests_run  = 0;
      tests_failed = 0;
      lfsr_state = 32'h1a26e7d1;
      row_prn  = '{1, 1, 7, 19, 0, 31, 0, 0};     // 0 selects PRN 32
      row_mode = '{MODE_MATCHED, MODE_INVERTED, MODE_CONST, MODE_MATCHED,
                   MODE_INVERTED, MODE_CONST, 0, 0};
      row_mag  = '{3, 1, 2, 0, 3, 0, 0, 0};
      for (r = 6; r < NUM_ROWS; r++) begin
         take_bits(5, v);
         row_prn[r] = v;
         take_bits(2, v);
         row_mode[r] = v % 3;
         take_bits(2, v);
         row_mag[r] = v;
      end
      for (r = 0; r < NUM_ROWS; r++) begin
         row_exp[r] = expected_dump(row_mode[r], row_mag[r],
                                    $countones(ca_sequence(row_prn[r])));
      end
      repeat (2) @(posedge clk_sample);           // Two cycles in reset
      @(negedge clk_sample);
      rst_n = 1'b1;
      @(negedge clk_sample);

      errs0 = errors;
      wb_read(gps_pkg::REG_CTRL, rd);
      if (rd !== 32'h0) report_mismatch("CTRL after reset", int'(rd), 0);
      wb_read(gps_pkg::REG_STATUS, rd);
      if (rd !== 32'h0) report_mismatch("STATUS after reset", int'(rd), 0);
      wb_read(gps_pkg::REG_DUMP, rd);
      if (rd !== 32'h0) report_mismatch("DUMP after reset", int'(rd), 0);
      if ({hex3, hex2, hex1, hex0} !== {4{SEG_REF[0]}}) begin
         report_mismatch("hex after reset", int'({hex3, hex2, hex1, hex0}), 0);
      end
      repeat (20) begin
         if (epoch_end !== 1'b0) report_mismatch("epoch_end while idle", int'(epoch_end), 0);
         @(negedge clk_sample);
      end
      finish_test("reset", errs0);

      errs0 = errors;
      wb_write(gps_pkg::REG_CTRL, ctrl_value(5, 1'b0), 4'hf);
      wb_write(gps_pkg::REG_CTRL, 32'hffff_ffff, 4'h0);  // No lanes selected
      wb_read(gps_pkg::REG_CTRL, rd);
      if (rd !== 32'h50) report_mismatch("CTRL after empty write", int'(rd), 'h50);
      wb_write(gps_pkg::REG_CTRL, 32'h0000_0100, 4'b0010);  // Byte 1 sets PRN bit 4
      wb_read(gps_pkg::REG_CTRL, rd);
      if (rd !== 32'h150) report_mismatch("CTRL after lane write", int'(rd), 'h150);
      wb_read(2'd3, rd);
      if (rd !== 32'h0) report_mismatch("unmapped read", int'(rd), 0);
      finish_test("wishbone", errs0);

      for (r = 0; r < NUM_ROWS; r++) begin
         errs0 = errors;
         run_row(r);
         finish_test($sformatf("row%0d", r), errs0);
      end

      errs0     = errors;
      last_code = ca_sequence(row_prn[NUM_ROWS - 1]);
      park_bit  = last_code[0];                   // Chip 0 of the last PRN
      wb_write(gps_pkg::REG_CTRL, ctrl_value(row_prn[NUM_ROWS - 1], 1'b0), 4'hf);
      repeat (3 * gps_pkg::SAMPLES_PER_CHIP) begin
         if (ca_bit !== park_bit) begin
            report_mismatch("ca_bit while stopped", int'(ca_bit), int'(park_bit));
         end
         if (epoch_end !== 1'b0) report_mismatch("epoch_end while stopped", int'(epoch_end), 0);
         @(negedge clk_sample);
      end
      wb_read(gps_pkg::REG_STATUS, rd);
      if (rd !== 32'h0) report_mismatch("STATUS after stop", int'(rd), 0);
      finish_test("stop", errs0);

      $display("tests run %0d, tests failed %0d, failed checks %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
gps_pkg.sv
hex_driver.sv
ca_code_gen.sv
ca_upsampler.sv
track_correlator.sv
wb_regs.sv
gps_track_top.sv
tb_gps_track.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then search the log for the pass line
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f vlog.f --top-module tb_gps_track \
   -o tb_gps_track > build.log 2>&1 \
   && ./obj_dir/tb_gps_track > sim.log 2>&1 \
   || echo "build or simulation did not complete, see build.log and sim.log"
grep -q "^TEST RESULT: PASS$" sim.log 2>/dev/null \
   && echo "simulation passed" && exit 0 \
   || { echo "simulation failed, see sim.log"; exit 1; }
